// ==== source/mem_stage_settings.svh ====
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// Data path and byte address width
`define MEM_DATA_W 64

// Width of an architectural register index
`define MEM_REG_IDX_W 5

// Core-local timer window, 64 KiB starting at the base
`define MEM_CLINT_BASE 64'h0000_0000_0200_0000
`define MEM_CLINT_MASK 64'hffff_ffff_ffff_0000

// Register offsets inside the timer window
`define MEM_MTIMECMP_OFS 16'h4000
`define MEM_MTIME_OFS    16'hbff8

`endif

// ==== source/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // Load width and sign handling, as decoded by the execute stage
    typedef enum logic [2:0] {
        LD_B  = 3'd0,
        LD_H  = 3'd1,
        LD_W  = 3'd2,
        LD_D  = 3'd3,
        LD_BU = 3'd4,
        LD_HU = 3'd5,
        LD_WU = 3'd6
    } load_type_e;

    // Encoding is log2 of the access size, so it goes straight onto the bus size field
    typedef enum logic [1:0] {
        ST_B = 2'd0,
        ST_H = 2'd1,
        ST_W = 2'd2,
        ST_D = 2'd3
    } store_type_e;

    typedef enum logic [1:0] {
        RESP_OK    = 2'd0,
        RESP_FAULT = 2'd2  // Slave could not decode the address
    } mem_resp_e;

endpackage

// ==== source/mem_access_if.sv ====
`include "mem_stage_settings.svh"

interface mem_access_if;
    import mem_stage_pkg::*;

    logic                   valid;
    logic                   req;    // High for a write
    logic [`MEM_DATA_W-1:0] addr;
    logic [1:0]             size;   // log2 of the access size in bytes
    logic [`MEM_DATA_W-1:0] wdata;  // Already on its byte lanes
    logic                   ready;  // One cycle per access
    logic [`MEM_DATA_W-1:0] rdata;  // Whole aligned doubleword
    mem_resp_e              resp;

    modport master (
        output valid, req, addr, size, wdata,
        input  ready, rdata, resp
    );

    modport slave (
        input  valid, req, addr, size, wdata,
        output ready, rdata, resp
    );

endinterface

// ==== source/mem_lsu.sv ====
`include "mem_stage_settings.svh"

module mem_lsu (
    input  logic                       temp,
    input  logic                       rst_i,

    input  logic                       inst_valid_i,
    input  logic                       mem_read_i,
    input  logic                       mem_write_i,
    input  mem_stage_pkg::load_type_e  load_type_i,
    input  mem_stage_pkg::store_type_e store_type_i,

    input  logic                       rs2_en_i,
    input  logic                       mem2wb_rd_en_i,
    input  logic [`MEM_REG_IDX_W-1:0]  rs2_index_i,
    input  logic [`MEM_REG_IDX_W-1:0]  mem2wb_rd_index_i,
    input  logic [`MEM_DATA_W-1:0]     rs2_data_i,
    input  logic [`MEM_DATA_W-1:0]     mem2wb_rd_data_i,
    input  logic [`MEM_DATA_W-1:0]     ex2mem_rd_data_i,

    mem_access_if.master               bus,

    output logic [`MEM_DATA_W-1:0]     rd_data_o,
    output logic                       access_ok_o,
    output logic                       access_fault_o
);
    import mem_stage_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_DONE
    } state_e;

    state_e                 state_q;
    logic                   fault_q;
    logic [`MEM_DATA_W-1:0] load_q;

    logic                   is_mem;
    logic                   fwd_rs2;
    logic [`MEM_DATA_W-1:0] store_data;
    logic [1:0]             load_size;
    logic [`MEM_DATA_W-1:0] load_shifted;
    logic [`MEM_DATA_W-1:0] load_ext;

    assign is_mem = mem_read_i | mem_write_i;

    // The instruction in writeback has not reached the register file yet
    assign fwd_rs2 = rs2_en_i && mem2wb_rd_en_i && (rs2_index_i == mem2wb_rd_index_i)
                     && (rs2_index_i != '0);
    assign store_data = fwd_rs2 ? mem2wb_rd_data_i : rs2_data_i;

    always_comb begin
        case (load_type_i)
            LD_B, LD_BU: load_size = 2'd0;
            LD_H, LD_HU: load_size = 2'd1;
            LD_W, LD_WU: load_size = 2'd2;
            default:     load_size = 2'd3;
        endcase
    end

    assign bus.valid = (state_q == S_BUSY);
    assign bus.req   = mem_write_i;
    assign bus.addr  = ex2mem_rd_data_i;
    assign bus.size  = mem_write_i ? store_type_i : load_size;

    // Aligned accesses land on the lane given by addr[2:0] once the data is replicated
    always_comb begin
        case (store_type_i)
            ST_B:    bus.wdata = {8{store_data[7:0]}};
            ST_H:    bus.wdata = {4{store_data[15:0]}};
            ST_W:    bus.wdata = {2{store_data[31:0]}};
            default: bus.wdata = store_data;
        endcase
    end

    assign load_shifted = bus.rdata >> {ex2mem_rd_data_i[2:0], 3'b000};

    always_comb begin
        case (load_type_i)
            LD_B:    load_ext = {{56{load_shifted[7]}}, load_shifted[7:0]};
            LD_H:    load_ext = {{48{load_shifted[15]}}, load_shifted[15:0]};
            LD_W:    load_ext = {{32{load_shifted[31]}}, load_shifted[31:0]};
            LD_BU:   load_ext = {56'd0, load_shifted[7:0]};
            LD_HU:   load_ext = {48'd0, load_shifted[15:0]};
            LD_WU:   load_ext = {32'd0, load_shifted[31:0]};
            default: load_ext = load_shifted;
        endcase
    end

    always_ff @(posedge temp) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            fault_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (inst_valid_i) begin
                        state_q <= is_mem ? S_BUSY : S_DONE;  // ALU results skip the bus
                        fault_q <= 1'b0;
                    end
                end
                S_BUSY: begin
                    if (bus.ready) begin
                        state_q <= S_DONE;
                        fault_q <= (bus.resp != RESP_OK);
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Stores and faulted accesses return zero
    always_ff @(posedge temp) begin
        if (state_q == S_BUSY && bus.ready) begin
            load_q <= (mem_read_i && bus.resp == RESP_OK) ? load_ext : '0;
        end
    end

    assign rd_data_o      = is_mem ? load_q : ex2mem_rd_data_i;
    assign access_ok_o    = (state_q == S_DONE);
    assign access_fault_o = (state_q == S_DONE) & fault_q;

endmodule

// ==== source/mem_dstb.sv ====
`include "mem_stage_settings.svh"

module mem_dstb (
    mem_access_if.slave                cpu,
    mem_access_if.master               clint,

    output logic                       mem_valid_o,
    output logic                       mem_req_o,
    output logic [`MEM_DATA_W-1:0]     mem_addr_o,
    output logic [1:0]                 mem_size_o,
    output logic [`MEM_DATA_W-1:0]     mem_wdata_o,
    input  logic                       mem_ready_i,
    input  logic [`MEM_DATA_W-1:0]     mem_rdata_i,
    input  mem_stage_pkg::mem_resp_e   mem_resp_i
);

    logic sel_clint;

    assign sel_clint = ((cpu.addr & `MEM_CLINT_MASK) == `MEM_CLINT_BASE);

    // Request fields go to both sides, only valid is steered
    assign clint.valid = cpu.valid & sel_clint;
    assign clint.req   = cpu.req;
    assign clint.addr  = cpu.addr;
    assign clint.size  = cpu.size;
    assign clint.wdata = cpu.wdata;

    assign mem_valid_o = cpu.valid & ~sel_clint;
    assign mem_req_o   = cpu.req;
    assign mem_addr_o  = cpu.addr;
    assign mem_size_o  = cpu.size;
    assign mem_wdata_o = cpu.wdata;

    assign cpu.ready = sel_clint ? clint.ready : mem_ready_i;
    assign cpu.rdata = sel_clint ? clint.rdata : mem_rdata_i;
    assign cpu.resp  = sel_clint ? clint.resp  : mem_resp_i;

endmodule

// ==== source/mem_clint.sv ====
`include "mem_stage_settings.svh"

module mem_clint (
    input  logic          temp,
    input  logic          rst_i,

    mem_access_if.slave   bus,

    output logic          mtip_o
);
    import mem_stage_pkg::*;

    localparam logic [15:0] mtimecmp_ofs = `MEM_MTIMECMP_OFS;
    localparam logic [15:0] mtime_ofs    = `MEM_MTIME_OFS;

    logic [`MEM_DATA_W-1:0]   mtime_q;
    logic [`MEM_DATA_W-1:0]   mtimecmp_q;
    logic                     ready_q;
    logic                     mtip_q;

    logic                     hit_cmp;
    logic                     hit_time;
    logic                     wr_en;
    logic [7:0]               byte_en;
    logic [`MEM_DATA_W-1:0]   wmask;

    assign hit_cmp  = (bus.addr[15:3] == mtimecmp_ofs[15:3]);
    assign hit_time = (bus.addr[15:3] == mtime_ofs[15:3]);
    assign wr_en    = ready_q & bus.valid & bus.req;

    // Narrow writes only touch their own bytes
    always_comb begin
        case (bus.size)
            2'd0:    byte_en = 8'h01 << bus.addr[2:0];
            2'd1:    byte_en = 8'h03 << bus.addr[2:0];
            2'd2:    byte_en = 8'h0f << bus.addr[2:0];
            default: byte_en = 8'hff;
        endcase
        for (int i = 0; i < 8; i++) begin
            wmask[i*8 +: 8] = {8{byte_en[i]}};
        end
    end

    always_ff @(posedge temp) begin
        if (rst_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;  // No interrupt until software programs a compare value
            ready_q    <= 1'b0;
            mtip_q     <= 1'b0;
        end else begin
            ready_q <= bus.valid & ~ready_q;
            mtip_q  <= (mtime_q >= mtimecmp_q);
            mtime_q <= mtime_q + 1'b1;
            if (wr_en && hit_time) begin
                mtime_q <= (mtime_q & ~wmask) | (bus.wdata & wmask);
            end
            if (wr_en && hit_cmp) begin
                mtimecmp_q <= (mtimecmp_q & ~wmask) | (bus.wdata & wmask);
            end
        end
    end

    assign bus.ready = ready_q;
    assign bus.rdata = hit_cmp ? mtimecmp_q : (hit_time ? mtime_q : '0);
    assign bus.resp  = (hit_cmp || hit_time) ? RESP_OK : RESP_FAULT;
    assign mtip_o    = mtip_q;

endmodule

// ==== source/mem_stage_top.sv ====
`include "mem_stage_settings.svh"

module mem_stage_top (
    input  logic                       temp,
    input  logic                       rst_i,

    input  logic                       inst_valid_i,
    input  logic                       mem_read_i,
    input  logic                       mem_write_i,
    input  mem_stage_pkg::load_type_e  load_type_i,
    input  mem_stage_pkg::store_type_e store_type_i,
    input  logic                       rs2_en_i,
    input  logic                       mem2wb_rd_en_i,
    input  logic [`MEM_REG_IDX_W-1:0]  rs2_index_i,
    input  logic [`MEM_REG_IDX_W-1:0]  mem2wb_rd_index_i,
    input  logic [`MEM_DATA_W-1:0]     rs2_data_i,
    input  logic [`MEM_DATA_W-1:0]     mem2wb_rd_data_i,
    input  logic [`MEM_DATA_W-1:0]     ex2mem_rd_data_i,

    output logic [`MEM_DATA_W-1:0]     rd_data_o,
    output logic                       access_ok_o,
    output logic                       access_fault_o,
    output logic                       mtip_o,

    output logic                       mem_valid_o,
    output logic                       mem_req_o,
    output logic [`MEM_DATA_W-1:0]     mem_addr_o,
    output logic [1:0]                 mem_size_o,
    output logic [`MEM_DATA_W-1:0]     mem_wdata_o,
    input  logic                       mem_ready_i,
    input  logic [`MEM_DATA_W-1:0]     mem_rdata_i,
    input  mem_stage_pkg::mem_resp_e   mem_resp_i
);

    mem_access_if lsu_bus ();
    mem_access_if clint_bus ();

    mem_lsu lsu_i (
        .temp              (temp),
        .rst_i             (rst_i),
        .inst_valid_i      (inst_valid_i),
        .mem_read_i        (mem_read_i),
        .mem_write_i       (mem_write_i),
        .load_type_i       (load_type_i),
        .store_type_i      (store_type_i),
        .rs2_en_i          (rs2_en_i),
        .mem2wb_rd_en_i    (mem2wb_rd_en_i),
        .rs2_index_i       (rs2_index_i),
        .mem2wb_rd_index_i (mem2wb_rd_index_i),
        .rs2_data_i        (rs2_data_i),
        .mem2wb_rd_data_i  (mem2wb_rd_data_i),
        .ex2mem_rd_data_i  (ex2mem_rd_data_i),
        .bus               (lsu_bus.master),
        .rd_data_o         (rd_data_o),
        .access_ok_o       (access_ok_o),
        .access_fault_o    (access_fault_o)
    );

    mem_dstb dstb_i (
        .cpu         (lsu_bus.slave),
        .clint       (clint_bus.master),
        .mem_valid_o (mem_valid_o),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_size_o  (mem_size_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ready_i (mem_ready_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_resp_i  (mem_resp_i)
    );

    mem_clint clint_i (
        .temp   (temp),
        .rst_i  (rst_i),
        .bus    (clint_bus.slave),
        .mtip_o (mtip_o)
    );

endmodule

// ==== sim/mem_stage_chk.sv ====
`include "mem_stage_settings.svh"

module mem_stage_chk (
    input logic                   temp,
    input logic                   rst_i,
    input logic                   mem_valid_o,
    input logic                   mem_req_o,
    input logic [`MEM_DATA_W-1:0] mem_addr_o,
    input logic [1:0]             mem_size_o,
    input logic [`MEM_DATA_W-1:0] mem_wdata_o,
    input logic                   mem_ready_i,
    input logic                   access_ok_o,
    input logic                   access_fault_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;  // Number of assertion failures so far

    // A request stays on the bus unchanged until the memory answers it
    assert property (@(posedge temp) disable iff (rst_i)
        mem_valid_o && !mem_ready_i |=> mem_valid_o
            && $stable({mem_req_o, mem_addr_o, mem_size_o, mem_wdata_o}))
    else begin
        $error("memory request dropped or changed before ready");
        fails++;
    end

    assert property (@(posedge temp) disable iff (rst_i) access_ok_o |=> !access_ok_o)
    else begin
        $error("access_ok_o held for more than one cycle");
        fails++;
    end

    assert property (@(posedge temp) disable iff (rst_i) access_fault_o |-> access_ok_o)
    else begin
        $error("access_fault_o without access_ok_o");
        fails++;
    end

endmodule

bind mem_stage_top mem_stage_chk chk_i (.*);

// ==== sim/mem_stage_tb.sv ====
`include "mem_stage_settings.svh"

module mem_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_stage_pkg::*;

    localparam int          TIMEOUT       = 64;
    localparam logic [63:0] MTIMECMP_ADDR = `MEM_CLINT_BASE + `MEM_MTIMECMP_OFS;
    localparam logic [63:0] MTIME_ADDR    = `MEM_CLINT_BASE + `MEM_MTIME_OFS;

    logic temp = 1'b0;
    logic rst_i, inst_valid_i, mem_read_i, mem_write_i, rs2_en_i, mem2wb_rd_en_i;
    logic access_ok_o, access_fault_o, mtip_o, mem_valid_o, mem_req_o, mem_ready_i;
    load_type_e  load_type_i;
    store_type_e store_type_i;
    mem_resp_e   mem_resp_i;
    logic [1:0]  mem_size_o;
    logic [`MEM_REG_IDX_W-1:0] rs2_index_i, mem2wb_rd_index_i;
    logic [`MEM_DATA_W-1:0] rs2_data_i, mem2wb_rd_data_i, ex2mem_rd_data_i, rd_data_o;
    logic [`MEM_DATA_W-1:0] mem_addr_o, mem_wdata_o, mem_rdata_i;

    logic [63:0] mem_model [logic [63:0]];  // What the DUT wrote to memory
    logic [63:0] ref_mem [logic [63:0]];    // What the DUT should have written
    logic [63:0] last_addr, last_wdata;
    logic [1:0]  last_size;
    logic        last_req;
    integer      seed = 32'h8863;
    int mem_wait = 0, mem_busy = 0, cycle_cnt = 0;
    int errors = 0, passed = 0, failed = 0;

    mem_stage_top dut_i (.*);

    always #2 temp = ~temp;

    // Never written doublewords read back a pattern of their address
    function automatic logic [63:0] fill(logic [63:0] dw);
        return {dw[31:0], dw[63:32]} ^ (dw * 64'h9e37_79b9_7f4a_7c15);
    endfunction

    function automatic logic [63:0] lane_mask(logic [2:0] ofs, int nb);
        logic [63:0] m;
        m = '0;
        for (int j = 0; j < nb; j++) m[(ofs + j) * 8 +: 8] = 8'hff;
        return m;
    endfunction

    function automatic logic [63:0] place(logic [63:0] src, logic [2:0] ofs, int nb);
        logic [63:0] p;
        p = '0;
        for (int j = 0; j < nb; j++) p[(ofs + j) * 8 +: 8] = src[j * 8 +: 8];
        return p;
    endfunction

    function automatic logic [63:0] extend_load(logic [63:0] dw, logic [2:0] ofs, load_type_e lt);
        logic [63:0] v;
        int          bits;
        v    = dw >> (8 * ofs);
        bits = 8 << (int'(lt) & 3);
        for (int i = bits; i < 64; i++) v[i] = (lt inside {LD_B, LD_H, LD_W}) ? v[bits - 1] : 1'b0;
        return v;
    endfunction

    function automatic logic [63:0] ref_read(logic [63:0] a);
        logic [63:0] dw;
        dw = {a[63:3], 3'b000};
        return ref_mem.exists(dw) ? ref_mem[dw] : fill(dw);
    endfunction

    // External memory answers each request after 0 to 3 idle cycles
    always @(posedge temp) begin
        logic [63:0] dw;
        logic [63:0] old;
        logic [63:0] m;
        dw  = {mem_addr_o[63:3], 3'b000};
        old = mem_model.exists(dw) ? mem_model[dw] : fill(dw);
        cycle_cnt   <= cycle_cnt + 1;
        mem_ready_i <= 1'b0;
        if (mem_valid_o) mem_busy <= mem_busy + 1;
        if (mem_valid_o && !mem_ready_i) begin
            if (mem_wait != 0) begin
                mem_wait <= mem_wait - 1;
            end else begin
                mem_ready_i <= 1'b1;
                mem_rdata_i <= old;
                m = lane_mask(mem_addr_o[2:0], 1 << mem_size_o);
                if (mem_req_o) mem_model[dw] = (old & ~m) | (mem_wdata_o & m);
                last_addr  <= mem_addr_o;
                last_size  <= mem_size_o;
                last_wdata <= mem_wdata_o;
                last_req   <= mem_req_o;
                mem_wait   <= $unsigned($random(seed)) % 4;
            end
        end
    end

    task automatic issue(input logic rd, input logic wr, input load_type_e lt,
                         input store_type_e st, input logic [63:0] a, input logic [63:0] src,
                         output logic [63:0] res, output logic flt, output int lat);
        @(posedge temp);
        inst_valid_i     <= 1'b1;
        mem_read_i       <= rd;
        mem_write_i      <= wr;
        load_type_i      <= lt;
        store_type_i     <= st;
        ex2mem_rd_data_i <= a;
        rs2_data_i       <= src;
        @(posedge temp);
        inst_valid_i <= 1'b0;
        lat = 1;
        while (!access_ok_o && lat < TIMEOUT) begin
            @(posedge temp);
            lat++;
        end
        res = rd_data_o;
        flt = access_fault_o;
        assert (access_ok_o) else begin
            $display("Instruction at address %h never completed", a);
            errors++;
        end
    endtask

    task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic close_test(input string name);
        $display("%s: %s with %0d errors", name, errors == 0 ? "passed" : "failed", errors);
        if (errors == 0) passed++;
        else failed++;
        errors = 0;
    endtask

    initial begin
        logic [63:0] a, src, wbd, res, exp, m, mt0, mt1;
        logic [4:0]  idx, idx2;
        logic        en, flt;
        int          nb, lat, busy0, c0, n;
        load_type_e  lt;
        store_type_e st;
        rst_i = 1'b1;
        {inst_valid_i, mem_read_i, mem_write_i, mem2wb_rd_en_i, mem_ready_i} = '0;
        {rs2_index_i, mem2wb_rd_index_i, rs2_data_i, mem2wb_rd_data_i, ex2mem_rd_data_i} = '0;
        rs2_en_i     = 1'b1;
        load_type_i  = LD_D;
        store_type_i = ST_D;
        mem_resp_i   = RESP_OK;
        mem_rdata_i  = '0;
        repeat (4) @(posedge temp);
        rst_i <= 1'b0;

        for (int i = 0; i < 200; i++) begin
            lt  = load_type_e'($unsigned($random(seed)) % 7);
            nb  = 1 << (int'(lt) & 3);
            a   = 64'h8000_0000 + ($unsigned($random(seed)) & 32'h1ff & ~(nb - 1));
            exp = extend_load(ref_read(a), a[2:0], lt);
            issue(1'b1, 1'b0, lt, ST_D, a, '0, res, flt, lat);
            expect_eq("load", exp, res);
            expect_eq("load req", 1'b0, last_req);
        end
        close_test("loads");

        for (int i = 0; i < 60; i++) begin
            st  = store_type_e'($random(seed) & 3);
            nb  = 1 << int'(st);
            a   = 64'h8000_0000 + ($unsigned($random(seed)) & 32'h1ff & ~(nb - 1));
            src = {$random(seed), $random(seed)};
            m   = lane_mask(a[2:0], nb);
            exp = (ref_read(a) & ~m) | (place(src, a[2:0], nb) & m);
            issue(1'b0, 1'b1, LD_D, st, a, src, res, flt, lat);
            expect_eq("store req", 1'b1, last_req);
            expect_eq("store size", st, last_size);
            expect_eq("store addr", a, last_addr);
            expect_eq("store lanes", place(src, a[2:0], nb) & m, last_wdata & m);
            ref_mem[{a[63:3], 3'b000}] = exp;
            issue(1'b1, 1'b0, LD_D, ST_D, {a[63:3], 3'b000}, '0, res, flt, lat);
            expect_eq("store merge", exp, res);
        end
        close_test("stores");

        for (int i = 0; i < 40; i++) begin
            idx  = ($random(seed) & 3) == 0 ? '0 : $random(seed);
            idx2 = ($random(seed) & 1) ? idx : $random(seed);
            en   = $random(seed);
            src  = {$random(seed), $random(seed)};
            wbd  = {$random(seed), $random(seed)};
            a    = 64'h8000_0000 + ($unsigned($random(seed)) & 32'h1f8);
            exp  = (en && idx == idx2 && idx != 0) ? wbd : src;  // Writeback result is newer
            rs2_index_i       <= idx;
            mem2wb_rd_index_i <= idx2;
            mem2wb_rd_en_i    <= en;
            mem2wb_rd_data_i  <= wbd;
            issue(1'b0, 1'b1, LD_D, ST_D, a, src, res, flt, lat);
            expect_eq("forwarding", exp, last_wdata);
            ref_mem[a] = exp;
        end
        mem2wb_rd_en_i <= 1'b0;
        close_test("forwarding");

        busy0 = mem_busy;
        for (int i = 0; i < 20; i++) begin
            a = {$random(seed), $random(seed)};
            issue(1'b0, 1'b0, LD_D, ST_D, a, '0, res, flt, lat);
            expect_eq("pass-through", a, res);
            require(lat == 2, "access_ok_o did not follow inst_valid_i by exactly one cycle");
        end
        require(mem_busy == busy0, "mem_valid_o rose for a non-memory instruction");
        close_test("pass-through");

        // Compare value far in the future so mtip_o stays low until it is reprogrammed
        busy0 = mem_busy;
        exp   = {$random(seed), $random(seed)} | 64'h8000_0000_0000_0000;
        issue(1'b0, 1'b1, LD_D, ST_D, MTIMECMP_ADDR, exp, res, flt, lat);
        require(lat == 4, "timer access did not finish three cycles after inst_valid_i");
        issue(1'b1, 1'b0, LD_D, ST_D, MTIMECMP_ADDR, '0, res, flt, lat);
        expect_eq("mtimecmp readback", exp, res);
        issue(1'b1, 1'b0, LD_D, ST_D, MTIME_ADDR, '0, mt0, flt, lat);
        issue(1'b1, 1'b0, LD_D, ST_D, MTIME_ADDR, '0, mt1, flt, lat);
        c0 = cycle_cnt;
        require(mt1 >= mt0, "mtime went backwards between two reads");
        require(mem_busy == busy0, "mem_valid_o rose during a timer access");
        issue(1'b0, 1'b1, LD_D, ST_D, MTIMECMP_ADDR, mt1 + 20, res, flt, lat);
        require(!mtip_o, "mtip_o high before mtime reached mtimecmp");
        n = 0;
        while (!mtip_o && n < TIMEOUT) begin
            @(posedge temp);
            n++;
        end
        require(mtip_o, "mtip_o never rose after mtime passed mtimecmp");
        // mtime equals mt1 + 20 nineteen cycles after c0 and the registered compare lags by one
        require(cycle_cnt - c0 == 20, "mtip_o did not rise one cycle after mtime reached mtimecmp");
        close_test("timer");

        issue(1'b1, 1'b0, LD_D, ST_D, `MEM_CLINT_BASE + 64'h0100, '0, res, flt, lat);
        require(flt, "no fault for a read at an unused timer offset");
        expect_eq("fault data", '0, res);
        issue(1'b0, 1'b1, LD_D, ST_D, `MEM_CLINT_BASE + 64'h0100, '1, res, flt, lat);
        require(flt, "no fault for a write at an unused timer offset");
        issue(1'b1, 1'b0, LD_D, ST_D, MTIMECMP_ADDR, '0, res, flt, lat);
        expect_eq("fault mtimecmp", mt1 + 20, res);
        close_test("fault");

        require(dut_i.chk_i.fails == 0, "a bus protocol assertion failed");
        close_test("protocol");
        $display("Tests passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_stage.f ====
+incdir+source
source/mem_stage_pkg.sv
source/mem_access_if.sv
source/mem_lsu.sv
source/mem_dstb.sv
source/mem_clint.sv
source/mem_stage_top.sv
sim/mem_stage_chk.sv
sim/mem_stage_tb.sv
